//--- Bender.yml
package:
  name: rob_bridge

sources:
  - files:
      - hw/rob_bridge_pkg.sv
      - hw/rob_slot_if.sv
      - hw/rob_bridge_ctrl.sv
      - hw/rob_store.sv
      - hw/req_fifo2.sv
      - hw/rob_bridge.sv

  - target: test
    files:
      - testbench/ooo_mem_model.sv
      - testbench/tb_rob_bridge.sv

//--- hw/req_fifo2.sv
// Two-entry request FIFO
`timescale 1ns/10ps

module req_fifo2
#(
    parameter int DATA_BITS = 8
)
(
    input  logic                 mem_source,
    input  logic                 arst_n,

    input  logic                 enq_en,
    input  logic [DATA_BITS-1:0] enq_data,
    output logic                 not_full,

    input  logic                 deq_en,
    output logic [DATA_BITS-1:0] first,
    output logic                 not_empty
);

    // Slot 0 is the head, slot 1 the skid entry
    logic                 valid0;
    logic                 valid1;
    logic [DATA_BITS-1:0] data1;

    logic                 load0_from1;
    logic                 load0_from_enq;
    logic                 load1;

    assign not_empty = valid0;
    assign not_full  = !valid1;

    assign load0_from1    = deq_en && valid1;
    assign load0_from_enq = enq_en && !valid1 && (!valid0 || deq_en);
    // Head stays occupied, so a new entry goes behind it
    assign load1          = enq_en && valid0 && (!deq_en || valid1);

    always_ff @(posedge mem_source or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else
        begin
            if (!valid0 || (deq_en && !valid1))
                valid0 <= enq_en;

            if (load1)
                valid1 <= 1'b1;
            else if (deq_en)
                valid1 <= 1'b0;
        end
    end

    always_ff @(posedge mem_source)
    begin
        if (load0_from1)
            first <= data1;
        else if (load0_from_enq)
            first <= enq_data;

        if (load1)
            data1 <= enq_data;
    end

endmodule

//--- hw/rob_bridge.sv
// Reorder bridge top level
`timescale 1ns/10ps

module rob_bridge
#(
    parameter int MAX_ACTIVE_RD         = 8,
    parameter int MAX_ACTIVE_WR         = 8,
    parameter int BLOCK_WRITE_WITH_READ = 0
)
(
    input  logic                                  mem_source,
    input  logic                                  arst_n,

    // Source read
    input  logic                                  src_rd_read,
    input  logic [rob_bridge_pkg::ADDR_W-1:0]     src_rd_address,
    input  logic [rob_bridge_pkg::SRC_USER_W-1:0] src_rd_user,
    output logic                                  src_rd_waitrequest,
    output logic                                  src_rd_readdatavalid,
    output logic [rob_bridge_pkg::DATA_W-1:0]     src_rd_readdata,
    output rob_bridge_pkg::rsp_t                  src_rd_response,
    output logic [rob_bridge_pkg::SRC_USER_W-1:0] src_rd_readresponseuser,

    // Source write
    input  logic                                  src_wr_write,
    input  logic [rob_bridge_pkg::ADDR_W-1:0]     src_wr_address,
    input  logic [rob_bridge_pkg::DATA_W-1:0]     src_wr_writedata,
    input  logic [rob_bridge_pkg::SRC_USER_W-1:0] src_wr_user,
    output logic                                  src_wr_waitrequest,
    output logic                                  src_wr_writeresponsevalid,
    output rob_bridge_pkg::rsp_t                  src_wr_response,
    output logic [rob_bridge_pkg::SRC_USER_W-1:0] src_wr_writeresponseuser,

    // Sink read
    output logic                                  snk_rd_read,
    output logic [rob_bridge_pkg::ADDR_W-1:0]     snk_rd_address,
    output logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_rd_user,
    input  logic                                  snk_rd_waitrequest,
    input  logic                                  snk_rd_readdatavalid,
    input  logic [rob_bridge_pkg::DATA_W-1:0]     snk_rd_readdata,
    input  rob_bridge_pkg::rsp_t                  snk_rd_response,
    input  logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_rd_readresponseuser,

    // Sink write
    output logic                                  snk_wr_write,
    output logic [rob_bridge_pkg::ADDR_W-1:0]     snk_wr_address,
    output logic [rob_bridge_pkg::DATA_W-1:0]     snk_wr_writedata,
    output logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_wr_user,
    input  logic                                  snk_wr_waitrequest,
    input  logic                                  snk_wr_writeresponsevalid,
    input  rob_bridge_pkg::rsp_t                  snk_wr_response,
    input  logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_wr_writeresponseuser
);

    import rob_bridge_pkg::*;

    logic          rd_req_en;
    logic          wr_req_en;
    logic          rd_fifo_not_full;
    logic          wr_fifo_not_full;
    sink_user_u    sink_rd_user;
    sink_user_u    sink_wr_user;

    // Returning user words, decoded for their reorder index
    sink_user_u    rd_rsp_user;
    sink_user_u    wr_rsp_user;

    logic [DATA_W+1:0] rd_out_data;
    logic [1:0]        wr_out_data;

    assign rd_rsp_user.raw = snk_rd_readresponseuser;
    assign wr_rsp_user.raw = snk_wr_writeresponseuser;

    assign src_rd_readdata = rd_out_data[DATA_W-1:0];
    assign src_rd_response = rsp_t'(rd_out_data[DATA_W+1:DATA_W]);
    assign src_wr_response = rsp_t'(wr_out_data);

    rob_slot_if #(.N_ENTRIES(MAX_ACTIVE_RD), .META_BITS(SRC_USER_W)) rd_slot ();
    rob_slot_if #(.N_ENTRIES(MAX_ACTIVE_WR), .META_BITS(SRC_USER_W)) wr_slot ();

    // ========================================================================
    // Control
    // ========================================================================

    rob_bridge_ctrl #(.BLOCK_WRITE_WITH_READ(BLOCK_WRITE_WITH_READ)) ctrl
    (
        .mem_source         (mem_source),
        .arst_n             (arst_n),
        .src_read           (src_rd_read),
        .src_write          (src_wr_write),
        .src_rd_user        (src_rd_user),
        .src_wr_user        (src_wr_user),
        .rd_fifo_not_full   (rd_fifo_not_full),
        .wr_fifo_not_full   (wr_fifo_not_full),
        .src_rd_waitrequest (src_rd_waitrequest),
        .src_wr_waitrequest (src_wr_waitrequest),
        .rd_req_en          (rd_req_en),
        .wr_req_en          (wr_req_en),
        .sink_rd_user       (sink_rd_user),
        .sink_wr_user       (sink_wr_user),
        .rd_slot            (rd_slot.ctrl),
        .wr_slot            (wr_slot.ctrl)
    );

    // ========================================================================
    // Reorder buffers
    // ========================================================================

    rob_store #(.N_ENTRIES(MAX_ACTIVE_RD), .DATA_BITS(DATA_W + 2)) rd_rob
    (
        .mem_source (mem_source),
        .arst_n     (arst_n),
        .slot       (rd_slot.store),
        .enq_en     (snk_rd_readdatavalid),
        .enq_idx    (rd_rsp_user.tag.rob_idx),
        .enq_data   ({snk_rd_response, snk_rd_readdata}),
        .valid      (src_rd_readdatavalid),
        .data       (rd_out_data),
        .meta       (src_rd_readresponseuser)
    );

    rob_store #(.N_ENTRIES(MAX_ACTIVE_WR), .DATA_BITS(2)) wr_rob
    (
        .mem_source (mem_source),
        .arst_n     (arst_n),
        .slot       (wr_slot.store),
        .enq_en     (snk_wr_writeresponsevalid),
        .enq_idx    (wr_rsp_user.tag.rob_idx),
        .enq_data   (snk_wr_response),
        .valid      (src_wr_writeresponsevalid),
        .data       (wr_out_data),
        .meta       (src_wr_writeresponseuser)
    );

    // ========================================================================
    // Request FIFOs
    // ========================================================================

    req_fifo2 #(.DATA_BITS(SINK_USER_W + ADDR_W)) rd_fifo
    (
        .mem_source (mem_source),
        .arst_n     (arst_n),
        .enq_en     (rd_req_en),
        .enq_data   ({sink_rd_user.raw, src_rd_address}),
        .not_full   (rd_fifo_not_full),
        .deq_en     (snk_rd_read && !snk_rd_waitrequest),
        .first      ({snk_rd_user, snk_rd_address}),
        .not_empty  (snk_rd_read)
    );

    req_fifo2 #(.DATA_BITS(SINK_USER_W + DATA_W + ADDR_W)) wr_fifo
    (
        .mem_source (mem_source),
        .arst_n     (arst_n),
        .enq_en     (wr_req_en),
        .enq_data   ({sink_wr_user.raw, src_wr_writedata, src_wr_address}),
        .not_full   (wr_fifo_not_full),
        .deq_en     (snk_wr_write && !snk_wr_waitrequest),
        .first      ({snk_wr_user, snk_wr_writedata, snk_wr_address}),
        .not_empty  (snk_wr_write)
    );

endmodule

//--- hw/rob_bridge_ctrl.sv
// Reorder bridge request control
`timescale 1ns/10ps

module rob_bridge_ctrl
#(
    parameter int BLOCK_WRITE_WITH_READ = 0
)
(
    input  logic                                mem_source,
    input  logic                                arst_n,

    input  logic                                src_read,
    input  logic                                src_write,
    input  logic [rob_bridge_pkg::SRC_USER_W-1:0] src_rd_user,
    input  logic [rob_bridge_pkg::SRC_USER_W-1:0] src_wr_user,

    input  logic                                rd_fifo_not_full,
    input  logic                                wr_fifo_not_full,

    output logic                                src_rd_waitrequest,
    output logic                                src_wr_waitrequest,
    output logic                                rd_req_en,
    output logic                                wr_req_en,

    output rob_bridge_pkg::sink_user_u          sink_rd_user,
    output rob_bridge_pkg::sink_user_u          sink_wr_user,

    rob_slot_if.ctrl                            rd_slot,
    rob_slot_if.ctrl                            wr_slot
);

    import rob_bridge_pkg::*;

    // ========================================================================
    // Read not-full debounce
    // ========================================================================

    // Refuse one cycle after the read buffer goes from full to not full
    logic rd_not_full;
    logic rd_was_full;

    assign rd_not_full = rd_slot.not_full && !rd_was_full;

    always_ff @(posedge mem_source or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // Buffers start empty
            rd_was_full <= 1'b0;
        end
        else
        begin
            rd_was_full <= !rd_slot.not_full;
        end
    end

    // ========================================================================
    // Waitrequest and allocation
    // ========================================================================

    assign src_rd_waitrequest = !(rd_not_full && rd_fifo_not_full);
    assign rd_req_en          = src_read && !src_rd_waitrequest;

    // Optional write stall while reads are out of slots
    assign src_wr_waitrequest = !wr_slot.not_full || !wr_fifo_not_full ||
                                ((BLOCK_WRITE_WITH_READ != 0) && !rd_not_full);
    assign wr_req_en          = src_write && !src_wr_waitrequest;

    assign rd_slot.alloc_en   = rd_req_en;
    assign rd_slot.alloc_meta = src_rd_user;
    assign wr_slot.alloc_en   = wr_req_en;
    assign wr_slot.alloc_meta = src_wr_user;

    // Sink user words carry the reorder index in the low field
    always_comb
    begin
        sink_rd_user.tag.user_hi = src_rd_user[SRC_USER_W-1 -: USER_HI_W];
        sink_rd_user.tag.rob_idx = ROB_IDX_W'(rd_slot.alloc_idx);
        sink_wr_user.tag.user_hi = src_wr_user[SRC_USER_W-1 -: USER_HI_W];
        sink_wr_user.tag.rob_idx = ROB_IDX_W'(wr_slot.alloc_idx);
    end

    // Store reports full, so no slot may be taken here
    a_rd_alloc_room: assert property (@(posedge mem_source) disable iff (!arst_n)
        rd_slot.alloc_en |-> rd_slot.not_full);

    a_wr_alloc_room: assert property (@(posedge mem_source) disable iff (!arst_n)
        wr_slot.alloc_en |-> wr_slot.not_full);

endmodule

//--- hw/rob_bridge_pkg.sv
// Reorder bridge shared definitions

package rob_bridge_pkg;

    // Bus widths
    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 32;
    localparam int SRC_USER_W  = 8;
    localparam int SINK_USER_W = 12;

    // Reorder index field inside the sink user word
    localparam int ROB_IDX_W = 8;
    localparam int USER_HI_W = SINK_USER_W - ROB_IDX_W;

    // Response codes, same encoding as the bus
    typedef enum logic [1:0]
    {
        RSP_OKAY   = 2'b00,
        RSP_SLVERR = 2'b10,
        RSP_DECERR = 2'b11
    } rsp_t;

    // Sink user word, either the raw bus value or the split tag view
    typedef union packed
    {
        logic [SINK_USER_W-1:0] raw;
        struct packed
        {
            // High bits of the source user word
            logic [USER_HI_W-1:0] user_hi;
            // Slot in the reorder buffer
            logic [ROB_IDX_W-1:0] rob_idx;
        } tag;
    } sink_user_u;

endpackage

//--- hw/rob_slot_if.sv
// Reorder buffer slot interface
`timescale 1ns/10ps

interface rob_slot_if
#(
    parameter int N_ENTRIES = 8,
    parameter int META_BITS = rob_bridge_pkg::SRC_USER_W
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    // Control to store
    logic                 alloc_en;
    logic [META_BITS-1:0] alloc_meta;

    // Store to control
    logic [IDX_W-1:0]     alloc_idx;
    logic                 not_full;

    modport ctrl
    (
        output alloc_en,
        output alloc_meta,
        input  alloc_idx,
        input  not_full
    );

    modport store
    (
        input  alloc_en,
        input  alloc_meta,
        output alloc_idx,
        output not_full
    );

endinterface

//--- hw/rob_store.sv
// Reorder buffer datapath
`timescale 1ns/10ps

module rob_store
#(
    parameter int N_ENTRIES = 8,
    parameter int DATA_BITS = 2
)
(
    input  logic                                  mem_source,
    input  logic                                  arst_n,

    rob_slot_if.store                             slot,

    // Out-of-order responses from the sink
    input  logic                                  enq_en,
    input  logic [rob_bridge_pkg::ROB_IDX_W-1:0]  enq_idx,
    input  logic [DATA_BITS-1:0]                  enq_data,

    // In-order responses to the source
    output logic                                  valid,
    output logic [DATA_BITS-1:0]                  data,
    output logic [rob_bridge_pkg::SRC_USER_W-1:0] meta
);

    import rob_bridge_pkg::*;

    localparam int IDX_W = $clog2(N_ENTRIES);

    logic [N_ENTRIES-1:0]  filled;
    logic [DATA_BITS-1:0]  data_mem [N_ENTRIES];
    logic [SRC_USER_W-1:0] meta_mem [N_ENTRIES];

    logic [IDX_W-1:0]      alloc_ptr;
    logic [IDX_W-1:0]      head_ptr;
    logic [IDX_W:0]        count;

    logic [IDX_W-1:0]      enq_slot;
    logic [IDX_W-1:0]      enq_offset;
    logic                  deq_en;

    // Read stage between the array and the output register
    logic                  rd_valid_q;
    logic [DATA_BITS-1:0]  rd_data_q;
    logic [SRC_USER_W-1:0] rd_meta_q;

    assign enq_slot   = enq_idx[IDX_W-1:0];
    assign enq_offset = enq_slot - head_ptr;
    assign deq_en     = filled[head_ptr];

    assign slot.alloc_idx = alloc_ptr;
    assign slot.not_full  = (count != (IDX_W+1)'(N_ENTRIES));

    // ========================================================================
    // Slot bookkeeping
    // ========================================================================

    always_ff @(posedge mem_source or negedge arst_n)
    begin
        if (!arst_n)
        begin
            filled     <= '0;
            alloc_ptr  <= '0;
            head_ptr   <= '0;
            count      <= '0;
            rd_valid_q <= 1'b0;
            valid      <= 1'b0;
        end
        else
        begin
            if (slot.alloc_en)
                alloc_ptr <= alloc_ptr + 1'b1;

            if (enq_en)
                filled[enq_slot] <= 1'b1;

            // Head leaves as soon as its response is in
            if (deq_en)
            begin
                filled[head_ptr] <= 1'b0;
                head_ptr         <= head_ptr + 1'b1;
            end

            if (slot.alloc_en && !deq_en)
                count <= count + 1'b1;
            else if (!slot.alloc_en && deq_en)
                count <= count - 1'b1;

            rd_valid_q <= deq_en;
            valid      <= rd_valid_q;
        end
    end

    // Payload storage and the two output stages
    always_ff @(posedge mem_source)
    begin
        if (slot.alloc_en)
            meta_mem[alloc_ptr] <= slot.alloc_meta;
        if (enq_en)
            data_mem[enq_slot] <= enq_data;

        rd_data_q <= data_mem[head_ptr];
        rd_meta_q <= meta_mem[head_ptr];
        data      <= rd_data_q;
        meta      <= rd_meta_q;
    end

    // Sink must echo an index that is in flight and not yet answered
    a_enq_slot_open: assert property (@(posedge mem_source) disable iff (!arst_n)
        enq_en |-> (enq_idx < N_ENTRIES) && !filled[enq_slot] &&
                   ({1'b0, enq_offset} < count));

endmodule

//--- sim.f
hw/rob_bridge_pkg.sv
hw/rob_slot_if.sv
hw/rob_bridge_ctrl.sv
hw/rob_store.sv
hw/req_fifo2.sv
hw/rob_bridge.sv
testbench/ooo_mem_model.sv
testbench/tb_rob_bridge.sv

//--- testbench/ooo_mem_model.sv
// Out-of-order sink memory model
`timescale 1ns/10ps

module ooo_mem_model
(
    input  logic                                   mem_source,
    input  logic                                   arst_n,
    input  logic                                   hold,

    input  logic                                   snk_rd_read,
    input  logic [rob_bridge_pkg::ADDR_W-1:0]      snk_rd_address,
    input  logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_rd_user,
    output logic                                   snk_rd_waitrequest,
    output logic                                   snk_rd_readdatavalid,
    output logic [rob_bridge_pkg::DATA_W-1:0]      snk_rd_readdata,
    output rob_bridge_pkg::rsp_t                   snk_rd_response,
    output logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_rd_readresponseuser,

    input  logic                                   snk_wr_write,
    input  logic [rob_bridge_pkg::ADDR_W-1:0]      snk_wr_address,
    input  logic [rob_bridge_pkg::DATA_W-1:0]      snk_wr_writedata,
    input  logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_wr_user,
    output logic                                   snk_wr_waitrequest,
    output logic                                   snk_wr_writeresponsevalid,
    output rob_bridge_pkg::rsp_t                   snk_wr_response,
    output logic [rob_bridge_pkg::SINK_USER_W-1:0] snk_wr_writeresponseuser
);

    import rob_bridge_pkg::*;

    localparam int DEPTH = 8;

    logic [DATA_W-1:0]      mem [256];
    logic [DATA_W-1:0]      rd_held_data [DEPTH];
    logic [SINK_USER_W-1:0] rd_held_user [DEPTH];
    logic [SINK_USER_W-1:0] wr_held_user [DEPTH];
    int                     rd_n;
    int                     wr_n;
    logic [31:0]            rng;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Stall once every holding slot is taken
    assign snk_rd_waitrequest = (rd_n == DEPTH);
    assign snk_wr_waitrequest = (wr_n == DEPTH);
    assign snk_rd_response    = RSP_OKAY;
    assign snk_wr_response    = RSP_OKAY;

    // ========================================================================
    // Accept, hold and release in scrambled order
    // ========================================================================

    always @(posedge mem_source or negedge arst_n)
    begin : serve
        int k;
        int n;
        if (!arst_n)
        begin
            rd_n                      <= 0;
            wr_n                      <= 0;
            rng                       <= 32'd62;
            snk_rd_readdatavalid      <= 1'b0;
            snk_rd_readdata           <= '0;
            snk_rd_readresponseuser   <= '0;
            snk_wr_writeresponsevalid <= 1'b0;
            snk_wr_writeresponseuser  <= '0;
        end
        else
        begin
            rng <= next_rand(rng);

            // Read channel, a random held entry leaves and the last one fills its place
            n = rd_n;
            snk_rd_readdatavalid <= 1'b0;
            if (!hold && n > 0 && rng[0])
            begin
                k = int'(rng[10:4]) % n;
                snk_rd_readdatavalid    <= 1'b1;
                snk_rd_readdata         <= rd_held_data[k];
                snk_rd_readresponseuser <= rd_held_user[k];
                rd_held_data[k] = rd_held_data[n-1];
                rd_held_user[k] = rd_held_user[n-1];
                n = n - 1;
            end
            if (snk_rd_read && !snk_rd_waitrequest)
            begin
                rd_held_data[n] = mem[snk_rd_address[7:0]];
                rd_held_user[n] = snk_rd_user;
                n = n + 1;
            end
            rd_n <= n;

            // Write channel, memory updated on acceptance
            n = wr_n;
            snk_wr_writeresponsevalid <= 1'b0;
            if (!hold && n > 0 && rng[1])
            begin
                k = int'(rng[14:8]) % n;
                snk_wr_writeresponsevalid <= 1'b1;
                snk_wr_writeresponseuser  <= wr_held_user[k];
                wr_held_user[k] = wr_held_user[n-1];
                n = n - 1;
            end
            if (snk_wr_write && !snk_wr_waitrequest)
            begin
                mem[snk_wr_address[7:0]] <= snk_wr_writedata;
                wr_held_user[n] = snk_wr_user;
                n = n + 1;
            end
            wr_n <= n;
        end
    end

endmodule

//--- testbench/tb_rob_bridge.sv
// Reorder bridge testbench
`timescale 1ns/10ps

module tb_rob_bridge;

    import rob_bridge_pkg::*;

    typedef struct
    {
        string                 name;
        bit                    is_wr;
        bit                    hold;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
        logic [SRC_USER_W-1:0] user;
        rsp_t                  rsp;
    } row_t;

    typedef struct
    {
        string                 name;
        logic [DATA_W-1:0]     data;
        rsp_t                  rsp;
        logic [SRC_USER_W-1:0] user;
    } exp_t;

    logic                   mem_source;
    logic                   arst_n;
    logic                   sink_hold;

    logic                   src_rd_read;
    logic [ADDR_W-1:0]      src_rd_address;
    logic [SRC_USER_W-1:0]  src_rd_user;
    logic                   src_rd_waitrequest;
    logic                   src_rd_readdatavalid;
    logic [DATA_W-1:0]      src_rd_readdata;
    rsp_t                   src_rd_response;
    logic [SRC_USER_W-1:0]  src_rd_readresponseuser;

    logic                   src_wr_write;
    logic [ADDR_W-1:0]      src_wr_address;
    logic [DATA_W-1:0]      src_wr_writedata;
    logic [SRC_USER_W-1:0]  src_wr_user;
    logic                   src_wr_waitrequest;
    logic                   src_wr_writeresponsevalid;
    rsp_t                   src_wr_response;
    logic [SRC_USER_W-1:0]  src_wr_writeresponseuser;

    logic                   snk_rd_read;
    logic [ADDR_W-1:0]      snk_rd_address;
    logic [SINK_USER_W-1:0] snk_rd_user;
    logic                   snk_rd_waitrequest;
    logic                   snk_rd_readdatavalid;
    logic [DATA_W-1:0]      snk_rd_readdata;
    rsp_t                   snk_rd_response;
    logic [SINK_USER_W-1:0] snk_rd_readresponseuser;

    logic                   snk_wr_write;
    logic [ADDR_W-1:0]      snk_wr_address;
    logic [DATA_W-1:0]      snk_wr_writedata;
    logic [SINK_USER_W-1:0] snk_wr_user;
    logic                   snk_wr_waitrequest;
    logic                   snk_wr_writeresponsevalid;
    rsp_t                   snk_wr_response;
    logic [SINK_USER_W-1:0] snk_wr_writeresponseuser;

    row_t                   rows [$];
    exp_t                   rd_exp [$];
    exp_t                   wr_exp [$];
    logic [DATA_W-1:0]      shadow [256];
    int                     cycles = 0;
    int                     cycle_limit = 0;

    rob_bridge #(.MAX_ACTIVE_RD(8), .MAX_ACTIVE_WR(8), .BLOCK_WRITE_WITH_READ(0)) rob_bridge_i
    (
        .*
    );

    ooo_mem_model sink_model
    (
        .*,
        .hold (sink_hold)
    );

    always #50 mem_source = ~mem_source;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // ========================================================================
    // Stimulus table
    // ========================================================================

    task automatic add_row(input string name, input bit is_wr, input bit hold,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [SRC_USER_W-1:0] user);
        row_t r;
        r.name  = name;
        r.is_wr = is_wr;
        r.hold  = hold;
        r.addr  = addr;
        r.wdata = wdata;
        r.user  = user;
        r.rsp   = RSP_OKAY;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] s;
        s = 32'd62;
        for (int i = 0; i < 8; i++)
            add_row("write_fill", 1'b1, 1'b0, ADDR_W'(16 + i),
                    DATA_W'(32'h1000_0000 + i * 32'h0101_0101), SRC_USER_W'(8'h40 + i));
        for (int i = 0; i < 8; i++)
            add_row("read_back", 1'b0, 1'b0, ADDR_W'(16 + (i * 3) % 8), '0,
                    SRC_USER_W'(8'h80 + i));
        // First eight are held in the sink, the ninth must stall
        for (int i = 0; i < 12; i++)
            add_row("rd_backpressure", 1'b0, i < 8, ADDR_W'(16 + i % 8), '0,
                    SRC_USER_W'(8'hC0 + i));
        // Mix writes land above the read region so no read races a write
        for (int i = 0; i < 32; i++)
        begin
            s = next_rand(s);
            if (s[0])
                add_row("random_mix", 1'b1, 1'b0, ADDR_W'(8'h80 + s[7:4]), s, s[23:16]);
            else
                add_row("random_mix", 1'b0, 1'b0, ADDR_W'(16 + s[10:8]), '0, s[23:16]);
        end
    endtask

    task automatic issue_request(input row_t r, input bit check_full);
        exp_t e;
        e.name = r.name;
        e.rsp  = r.rsp;
        e.user = r.user;
        e.data = shadow[r.addr[7:0]];
        if (r.is_wr)
        begin
            src_wr_write     = 1'b1;
            src_wr_address   = r.addr;
            src_wr_writedata = r.wdata;
            src_wr_user      = r.user;
        end
        else
        begin
            src_rd_read    = 1'b1;
            src_rd_address = r.addr;
            src_rd_user    = r.user;
        end
        @(negedge mem_source);
        if (check_full)
        begin
            if (src_rd_waitrequest !== 1'b1)
                report_failure("Read was not stalled with all read slots outstanding");
            sink_hold = 1'b0;
        end
        while ((r.is_wr ? src_wr_waitrequest : src_rd_waitrequest) !== 1'b0)
            @(negedge mem_source);
        if (r.is_wr)
        begin
            shadow[r.addr[7:0]] = r.wdata;
            wr_exp.push_back(e);
        end
        else
            rd_exp.push_back(e);
        @(posedge mem_source);
        #10;
        src_rd_read  = 1'b0;
        src_wr_write = 1'b0;
    endtask

    task automatic wait_drained();
        while (rd_exp.size() != 0 || wr_exp.size() != 0)
        begin
            @(posedge mem_source);
            #10;
        end
    endtask

    // ========================================================================
    // Response checks
    // ========================================================================

    task automatic check_read(input logic [DATA_W-1:0] data, input rsp_t rsp,
                              input logic [SRC_USER_W-1:0] user);
        exp_t e;
        if (rd_exp.size() == 0)
            report_failure("Read response arrived with no read outstanding");
        e = rd_exp.pop_front();
        if (data !== e.data)
            report_failure($sformatf("MISMATCH %s read data: expected %h actual %h",
                                     e.name, e.data, data));
        if (rsp !== e.rsp)
            report_failure($sformatf("MISMATCH %s read response: expected %h actual %h",
                                     e.name, e.rsp, rsp));
        if (user !== e.user)
            report_failure($sformatf("MISMATCH %s read user: expected %h actual %h",
                                     e.name, e.user, user));
    endtask

    task automatic check_write(input rsp_t rsp, input logic [SRC_USER_W-1:0] user);
        exp_t e;
        if (wr_exp.size() == 0)
            report_failure("Write response arrived with no write outstanding");
        e = wr_exp.pop_front();
        if (rsp !== e.rsp)
            report_failure($sformatf("MISMATCH %s write response: expected %h actual %h",
                                     e.name, e.rsp, rsp));
        if (user !== e.user)
            report_failure($sformatf("MISMATCH %s write user: expected %h actual %h",
                                     e.name, e.user, user));
    endtask

    always @(negedge mem_source)
    begin
        if (arst_n && src_rd_readdatavalid)
            check_read(src_rd_readdata, src_rd_response, src_rd_readresponseuser);
        if (arst_n && src_wr_writeresponsevalid)
            check_write(src_wr_response, src_wr_writeresponseuser);
    end

    always @(posedge mem_source)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
            report_failure("Timeout, the tests did not finish within the cycle limit");
    end

    initial
    begin
        string prev_name;
        mem_source       = 1'b0;
        arst_n           = 1'b0;
        sink_hold        = 1'b0;
        src_rd_read      = 1'b0;
        src_rd_address   = '0;
        src_rd_user      = '0;
        src_wr_write     = 1'b0;
        src_wr_address   = '0;
        src_wr_writedata = '0;
        src_wr_user      = '0;
        build_table();
        cycle_limit = 40 * rows.size();

        repeat (16) @(posedge mem_source);
        #10;
        arst_n = 1'b1;
        @(negedge mem_source);
        if (src_rd_readdatavalid !== 1'b0 || src_wr_writeresponsevalid !== 1'b0 ||
            snk_rd_read !== 1'b0 || snk_wr_write !== 1'b0)
            report_failure("Source valid or sink request not low after reset");
        @(posedge mem_source);
        #10;

        // Each new test starts from an idle bridge
        prev_name = "";
        foreach (rows[i])
        begin
            if (rows[i].name != prev_name)
                wait_drained();
            prev_name = rows[i].name;
            if (rows[i].hold)
                sink_hold = 1'b1;
            issue_request(rows[i], sink_hold && !rows[i].hold);
        end
        wait_drained();
        repeat (4) @(posedge mem_source);
        $display("Done: no errors");
        $finish;
    end

endmodule
